//--- source/bus_pkg.sv
package bus_pkg;

	// --------------------
	// Transfer and response codes
	localparam logic [1:0] TRANS_NONSEQ = 2'b10;
	localparam logic [1:0] TRANS_SEQ    = 2'b11;
	localparam logic [1:0] RESP_OKAY    = 2'b00;

	// --------------------
	// Register map, word aligned
	localparam int W_REG_SEL    = 4;
	localparam int ADDR_SEL_LSB = 2;	// Byte offset below the select
	localparam int ADDR_PIX_LSB = 8;	// Pixel index sits above two spare bits

	localparam logic [W_REG_SEL-1:0] REG_WIDTH_HEIGHT = 4'd1;
	localparam logic [W_REG_SEL-1:0] REG_DELAY_PARAMS = 4'd2;	// start_up 11:0, hsync 23:12
	localparam logic [W_REG_SEL-1:0] REG_LAYER_CONFIG = 4'd4;
	localparam logic [W_REG_SEL-1:0] REG_INPUT_IMAGE  = 4'd5;	// One pixel per write
	localparam logic [W_REG_SEL-1:0] REG_LAYER_START  = 4'd8;
	localparam logic [W_REG_SEL-1:0] REG_LAYER_DONE   = 4'd9;

	// Slave side inputs, 69 bits
	typedef struct packed {
		logic        sel;
		logic        ready;
		logic [1:0]  trans;
		logic [31:0] addr;
		logic        write;
		logic [31:0] wdata;
	} ahb_req_t;

	typedef struct packed {
		logic [3:0]  rsv_hi;
		logic [11:0] height;	// Bits 27:16
		logic [3:0]  rsv_lo;
		logic [11:0] width;	// Bits 11:0
	} geom_t;

	typedef struct packed {
		logic [15:0] rsv_hi;
		logic [2:0]  act_shift;	// Bits 15:13
		logic [4:0]  bias_shift;	// Bits 12:8
		logic [3:0]  rsv_mid;
		logic        act_type;	// 0 ReLU, 1 linear
		logic        rsv_b2;
		logic        rsv_b1;
		logic        is_first_layer;
	} layer_cfg_t;

	// Same write word, decoded per target register
	typedef union packed {
		geom_t       geom;
		layer_cfg_t  layer;
		logic [31:0] raw;
	} cfg_word_u;

endpackage

//--- source/cnn_pkg.sv
package cnn_pkg;

	// --------------------
	// Widths and limits
	localparam int PIX_W        = 8;
	localparam int N_TAP        = 9;	// 3x3 window
	localparam int N_CH         = 4;	// Output channels in parallel
	localparam int MAX_FRAME    = 256;	// Up to 16x16
	localparam int W_PIX_IDX    = 8;
	localparam int W_SIZE       = 12;
	localparam int W_DELAY      = 12;
	localparam int ACC_W        = 20;	// Nine 8x8 signed products
	localparam int PARAM_W      = 16;
	localparam int KERN_LATENCY = 4;	// Window valid to result valid

	typedef struct packed {
		logic [N_TAP-1:0][PIX_W-1:0] tap;	// tap[0] top left, raster order
	} window_t;

	typedef struct packed {
		logic [W_SIZE-1:0]  width;
		logic [W_SIZE-1:0]  height;
		logic [W_DELAY-1:0] start_up_delay;
		logic [W_DELAY-1:0] hsync_delay;
	} frame_cfg_t;

	typedef struct packed {
		logic       act_type;
		logic [4:0] bias_shift;
		logic [2:0] act_shift;
	} quant_cfg_t;

	localparam frame_cfg_t FRAME_CFG_RST = '{width: 12'd4, height: 12'd4,
		start_up_delay: 12'd8, hsync_delay: 12'd4};
	localparam quant_cfg_t QUANT_CFG_RST = '{act_type: 1'b0, bias_shift: 5'd9, act_shift: 3'd7};

	// --------------------
	// First layer coefficients, taps in raster order
	localparam logic signed [PIX_W-1:0] WEIGHTS [N_CH][N_TAP] = '{
		'{8'h8E, 8'h97, 8'hD7, 8'h7F, 8'hA3, 8'hCD, 8'hE5, 8'hFF, 8'h71},
		'{8'h45, 8'hB5, 8'hD1, 8'h13, 8'h80, 8'h5F, 8'hDD, 8'h79, 8'h08},
		'{8'h0D, 8'hF4, 8'hFF, 8'hF1, 8'h7F, 8'hF0, 8'hFC, 8'hED, 8'h01},
		'{8'h45, 8'h87, 8'hEB, 8'h80, 8'h20, 8'h5A, 8'h30, 8'h34, 8'hD3}
	};
	localparam logic [PARAM_W-1:0] SCALES [N_CH] = '{16'd95, 16'd103, 16'd364, 16'd170};
	localparam logic signed [PARAM_W-1:0] BIASES [N_CH] = '{
		-16'sd18620, 16'sd8060, 16'sd370, -16'sd506
	};

endpackage

//--- source/conv_act_quant.sv
`timescale 1ns/1ps
module conv_act_quant (
	input  logic                                clk,
	input  logic                                rstn,
	input  logic signed [cnn_pkg::ACC_W-1:0]    acc_i,
	input  logic                                vld_i,
	input  logic [cnn_pkg::PARAM_W-1:0]         scale_i,
	input  logic signed [cnn_pkg::PARAM_W-1:0]  bias_i,
	input  cnn_pkg::quant_cfg_t                 quant_cfg_i,
	output logic [cnn_pkg::PIX_W-1:0]           act_o,
	output logic                                vld_o
);

	logic signed [cnn_pkg::ACC_W+cnn_pkg::PARAM_W:0]    scl_q;	// Scaled, bias shifted
	logic signed [cnn_pkg::ACC_W+cnn_pkg::PARAM_W+1:0]  pre_c;	// Room for bias add
	logic [cnn_pkg::PIX_W-1:0]                          act_c;
	logic                                               vld_q;

	// Stage 2 arithmetic and clamp
	always_comb begin
		pre_c = (scl_q + bias_i) >>> quant_cfg_i.act_shift;
		if (!quant_cfg_i.act_type) begin	// ReLU, clamp 0..255
			if (pre_c < 0) begin
				act_c = '0;
			end else if (pre_c > 255) begin
				act_c = 8'hFF;
			end else begin
				act_c = pre_c[cnn_pkg::PIX_W-1:0];
			end
		end else begin	// Linear, two's complement byte
			if (pre_c < -128) begin
				act_c = 8'h80;
			end else if (pre_c > 127) begin
				act_c = 8'h7F;
			end else begin
				act_c = pre_c[cnn_pkg::PIX_W-1:0];
			end
		end
	end

	always_ff @(posedge clk) begin
		scl_q <= (acc_i * $signed({1'b0, scale_i})) >>> quant_cfg_i.bias_shift;	// Stage 1
		act_o <= act_c;	// Stage 2
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			vld_q <= 1'b0;
			vld_o <= 1'b0;
		end else begin
			vld_q <= vld_i;
			vld_o <= vld_q;
		end
	end

endmodule

//--- source/conv_kern.sv
`timescale 1ns/1ps
module conv_kern #(
	parameter int CH = 0	// Channel row of the coefficient tables, 0 to 3
) (
	input  logic                       clk,
	input  logic                       rstn,
	input  cnn_pkg::window_t           win_i,
	input  logic                       win_vld_i,
	input  cnn_pkg::quant_cfg_t        quant_cfg_i,
	output logic [cnn_pkg::PIX_W-1:0]  act_o,
	output logic                       vld_o
);

	logic signed [2*cnn_pkg::PIX_W:0]   prod_q [cnn_pkg::N_TAP];	// 9b x 8b signed
	logic signed [cnn_pkg::ACC_W-1:0]   sum_c, sum_q;
	logic [cnn_pkg::KERN_LATENCY-3:0]   vld_sr;	// Stages ahead of quantizer

	// --------------------
	// Product and sum stages
	always_ff @(posedge clk) begin
		for (int k = 0; k < cnn_pkg::N_TAP; k++) begin
			prod_q[k] <= $signed({1'b0, win_i.tap[k]}) * cnn_pkg::WEIGHTS[CH][k];	// Pixel unsigned
		end
		sum_q <= sum_c;
	end

	always_comb begin
		sum_c = '0;
		for (int k = 0; k < cnn_pkg::N_TAP; k++) begin
			sum_c = sum_c + prod_q[k];
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			vld_sr <= '0;
		end else begin
			vld_sr <= {vld_sr[cnn_pkg::KERN_LATENCY-4:0], win_vld_i};
		end
	end

	// Scale, bias, activation
	conv_act_quant u_quant (
		.clk         (clk),
		.rstn        (rstn),
		.acc_i       (sum_q),
		.vld_i       (vld_sr[cnn_pkg::KERN_LATENCY-3]),
		.scale_i     (cnn_pkg::SCALES[CH]),
		.bias_i      (cnn_pkg::BIASES[CH]),
		.quant_cfg_i (quant_cfg_i),
		.act_o       (act_o),
		.vld_o       (vld_o)
	);

endmodule

//--- source/img_window_buf.sv
`timescale 1ns/1ps
module img_window_buf (
	input  logic                           clk,
	input  logic                           rstn,
	input  logic                           pix_we_i,
	input  logic [cnn_pkg::W_PIX_IDX-1:0]  pix_idx_i,
	input  logic [cnn_pkg::PIX_W-1:0]      pix_data_i,
	input  cnn_pkg::frame_cfg_t            frame_cfg_i,
	input  logic                           first_layer_i,
	input  logic                           data_run_i,
	input  logic [cnn_pkg::W_SIZE-1:0]     row_i,
	input  logic [cnn_pkg::W_SIZE-1:0]     col_i,
	output cnn_pkg::window_t               win_o,
	output logic                           win_vld_o
);

	logic [cnn_pkg::PIX_W-1:0]      mem [cnn_pkg::MAX_FRAME];
	logic                           we_q;
	logic [cnn_pkg::W_PIX_IDX-1:0]  widx_q;
	logic [cnn_pkg::PIX_W-1:0]      wdat_q;
	logic [2*cnn_pkg::W_SIZE-1:0]   lin;	// Full raster product
	logic [cnn_pkg::W_PIX_IDX-1:0]  ctr, up, dn, w8;
	logic                           first_row, last_row, first_col, last_col;

	// --------------------
	// Write port, one stage behind the bus
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			we_q <= 1'b0;
		end else begin
			we_q <= pix_we_i;
		end
	end

	always_ff @(posedge clk) begin
		widx_q <= pix_idx_i;
		wdat_q <= pix_data_i;
		if (we_q) begin
			mem[widx_q] <= wdat_q;
		end
	end

	// --------------------
	// Window fetch around row, col
	assign lin = row_i * frame_cfg_i.width + col_i;
	assign ctr = lin[cnn_pkg::W_PIX_IDX-1:0];
	assign w8  = frame_cfg_i.width[cnn_pkg::W_PIX_IDX-1:0];
	assign up  = ctr - w8;	// Row above, wraps harmlessly at border
	assign dn  = ctr + w8;

	assign first_row = (row_i == '0);
	assign last_row  = (row_i == frame_cfg_i.height - 1'b1);
	assign first_col = (col_i == '0);
	assign last_col  = (col_i == frame_cfg_i.width - 1'b1);

	// Zero padding outside the frame
	assign win_o.tap[0] = (first_row || first_col) ? '0 : mem[up - 1'b1];
	assign win_o.tap[1] = first_row                ? '0 : mem[up];
	assign win_o.tap[2] = (first_row || last_col)  ? '0 : mem[up + 1'b1];
	assign win_o.tap[3] = first_col                ? '0 : mem[ctr - 1'b1];
	assign win_o.tap[4] = mem[ctr];
	assign win_o.tap[5] = last_col                 ? '0 : mem[ctr + 1'b1];
	assign win_o.tap[6] = (last_row || first_col)  ? '0 : mem[dn - 1'b1];
	assign win_o.tap[7] = last_row                 ? '0 : mem[dn];
	assign win_o.tap[8] = (last_row || last_col)   ? '0 : mem[dn + 1'b1];

	assign win_vld_o = data_run_i & first_layer_i;	// Kernels idle on later layers

endmodule

//--- source/cnn_ctrl.sv
`timescale 1ns/1ps
module cnn_ctrl (
	input  logic                               clk,
	input  logic                               rstn,
	input  bus_pkg::ahb_req_t                  bus_i,
	output logic                               hready_o,
	output logic [1:0]                         hresp_o,
	output logic [31:0]                        hrdata_o,
	output cnn_pkg::frame_cfg_t                frame_cfg_o,
	output cnn_pkg::quant_cfg_t                quant_cfg_o,
	output logic                               first_layer_o,
	output logic                               pix_we_o,
	output logic [cnn_pkg::W_PIX_IDX-1:0]      pix_idx_o,
	output logic [cnn_pkg::PIX_W-1:0]          pix_data_o,
	output logic                               data_run_o,
	output logic [cnn_pkg::W_SIZE-1:0]         row_o,
	output logic [cnn_pkg::W_SIZE-1:0]         col_o
);

	logic [bus_pkg::W_REG_SEL-1:0]  q_sel;	// Address phase select
	logic                           q_wr;
	logic [cnn_pkg::W_PIX_IDX-1:0]  q_pix_idx;
	bus_pkg::cfg_word_u             wr_w, rd_w;
	logic                           accept, start, busy;
	logic                           vsync_run, data_run, hsync_run, done;
	logic [cnn_pkg::W_DELAY-1:0]    vsync_cnt, hsync_cnt;
	logic [cnn_pkg::W_SIZE-1:0]     row, col;

	// --------------------
	// Address phase
	assign accept = bus_i.sel && bus_i.ready &&
		(bus_i.trans == bus_pkg::TRANS_NONSEQ || bus_i.trans == bus_pkg::TRANS_SEQ);

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			q_sel <= '0;
			q_wr  <= 1'b0;
		end else if (accept) begin
			q_sel <= bus_i.addr[bus_pkg::ADDR_SEL_LSB +: bus_pkg::W_REG_SEL];
			q_wr  <= bus_i.write;
		end else begin
			q_wr <= 1'b0;	// Select held for readback
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			q_pix_idx <= bus_i.addr[bus_pkg::ADDR_PIX_LSB +: cnn_pkg::W_PIX_IDX];
		end
	end

	// --------------------
	// Data phase writes
	assign wr_w.raw = bus_i.wdata;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			frame_cfg_o   <= cnn_pkg::FRAME_CFG_RST;
			quant_cfg_o   <= cnn_pkg::QUANT_CFG_RST;
			first_layer_o <= 1'b0;
		end else if (q_wr) begin
			case (q_sel)
				bus_pkg::REG_WIDTH_HEIGHT: begin
					frame_cfg_o.width  <= wr_w.geom.width;
					frame_cfg_o.height <= wr_w.geom.height;
				end
				bus_pkg::REG_DELAY_PARAMS: begin
					frame_cfg_o.start_up_delay <= wr_w.raw[cnn_pkg::W_DELAY-1:0];
					frame_cfg_o.hsync_delay    <= wr_w.raw[2*cnn_pkg::W_DELAY-1:cnn_pkg::W_DELAY];
				end
				bus_pkg::REG_LAYER_CONFIG: begin
					first_layer_o          <= wr_w.layer.is_first_layer;
					quant_cfg_o.act_type   <= wr_w.layer.act_type;
					quant_cfg_o.bias_shift <= wr_w.layer.bias_shift;
					quant_cfg_o.act_shift  <= wr_w.layer.act_shift;
				end
				default: ;	// Image and start handled below
			endcase
		end
	end

	// Pixel strobe straight from the data phase
	assign pix_we_o   = q_wr && (q_sel == bus_pkg::REG_INPUT_IMAGE);
	assign pix_idx_o  = q_pix_idx;
	assign pix_data_o = wr_w.raw[cnn_pkg::PIX_W-1:0];

	assign busy  = vsync_run | data_run | hsync_run;
	assign start = q_wr && (q_sel == bus_pkg::REG_LAYER_START) && wr_w.raw[0] && !busy;

	// --------------------
	// Readback, valid in the data phase
	always_comb begin
		rd_w = '0;
		case (q_sel)
			bus_pkg::REG_WIDTH_HEIGHT: begin
				rd_w.geom.width  = frame_cfg_o.width;
				rd_w.geom.height = frame_cfg_o.height;
			end
			bus_pkg::REG_DELAY_PARAMS: begin
				rd_w.raw = {8'd0, frame_cfg_o.hsync_delay, frame_cfg_o.start_up_delay};
			end
			bus_pkg::REG_LAYER_CONFIG: begin
				rd_w.layer.is_first_layer = first_layer_o;
				rd_w.layer.act_type       = quant_cfg_o.act_type;
				rd_w.layer.bias_shift     = quant_cfg_o.bias_shift;
				rd_w.layer.act_shift      = quant_cfg_o.act_shift;
			end
			bus_pkg::REG_LAYER_START: rd_w.raw = {31'd0, busy};
			bus_pkg::REG_LAYER_DONE:  rd_w.raw = {31'd0, done};
			default: ;	// Unmapped reads zero
		endcase
	end

	assign hrdata_o = rd_w.raw;
	assign hready_o = 1'b1;	// No wait states
	assign hresp_o  = bus_pkg::RESP_OKAY;

	// --------------------
	// Frame sequencer, one flag per phase
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			vsync_run <= 1'b0;
			data_run  <= 1'b0;
			hsync_run <= 1'b0;
			done      <= 1'b0;
			vsync_cnt <= '0;
			hsync_cnt <= '0;
			row       <= '0;
			col       <= '0;
		end else begin
			if (start) begin
				vsync_run <= 1'b1;
				vsync_cnt <= '0;
				row       <= '0;
				col       <= '0;
				done      <= 1'b0;
			end
			if (vsync_run) begin
				if (vsync_cnt == frame_cfg_o.start_up_delay - 1'b1) begin
					vsync_run <= 1'b0;
					data_run  <= 1'b1;	// First row begins
				end else begin
					vsync_cnt <= vsync_cnt + 1'b1;
				end
			end
			if (data_run) begin
				if (col == frame_cfg_o.width - 1'b1) begin
					data_run  <= 1'b0;
					hsync_run <= 1'b1;
					hsync_cnt <= '0;
				end else begin
					col <= col + 1'b1;
				end
			end
			if (hsync_run) begin
				if (hsync_cnt == frame_cfg_o.hsync_delay - 1'b1) begin
					hsync_run <= 1'b0;
					col       <= '0;
					if (row == frame_cfg_o.height - 1'b1) begin
						done <= 1'b1;	// Held until next start
					end else begin
						row      <= row + 1'b1;
						data_run <= 1'b1;
					end
				end else begin
					hsync_cnt <= hsync_cnt + 1'b1;
				end
			end
		end
	end

	assign data_run_o = data_run;
	assign row_o      = row;
	assign col_o      = col;

endmodule

//--- source/cnn_accel_top.sv
`timescale 1ns/1ps
module cnn_accel_top (
	input  logic               clk,
	input  logic               rstn,
	input  bus_pkg::ahb_req_t  bus_i,
	output logic               hready_o,
	output logic [1:0]         hresp_o,
	output logic [31:0]        hrdata_o,
	output logic [31:0]        out_pixel_o,
	output logic               out_valid_o
);

	cnn_pkg::frame_cfg_t                             frame_cfg;
	cnn_pkg::quant_cfg_t                             quant_cfg;
	logic                                            first_layer, pix_we, data_run;
	logic [cnn_pkg::W_PIX_IDX-1:0]                   pix_idx;
	logic [cnn_pkg::PIX_W-1:0]                       pix_data;
	logic [cnn_pkg::W_SIZE-1:0]                      row, col;
	cnn_pkg::window_t                                win;
	logic                                            win_vld;
	logic [cnn_pkg::N_CH-1:0][cnn_pkg::PIX_W-1:0]    ch_act;	// Channel 0 in low byte
	logic [cnn_pkg::N_CH-1:0]                        ch_vld;

	cnn_ctrl u_ctrl (
		.clk (clk), .rstn (rstn), .bus_i (bus_i),
		.hready_o (hready_o), .hresp_o (hresp_o), .hrdata_o (hrdata_o),
		.frame_cfg_o (frame_cfg), .quant_cfg_o (quant_cfg), .first_layer_o (first_layer),
		.pix_we_o (pix_we), .pix_idx_o (pix_idx), .pix_data_o (pix_data),
		.data_run_o (data_run), .row_o (row), .col_o (col)
	);

	img_window_buf u_win (
		.clk (clk), .rstn (rstn),
		.pix_we_i (pix_we), .pix_idx_i (pix_idx), .pix_data_i (pix_data),
		.frame_cfg_i (frame_cfg), .first_layer_i (first_layer),
		.data_run_i (data_run), .row_i (row), .col_i (col),
		.win_o (win), .win_vld_o (win_vld)
	);

	// --------------------
	// Kernels share one window
	for (genvar ch = 0; ch < cnn_pkg::N_CH; ch++) begin : g_kern
		conv_kern #(.CH(ch)) u_kern (
			.clk (clk), .rstn (rstn),
			.win_i (win), .win_vld_i (win_vld), .quant_cfg_i (quant_cfg),
			.act_o (ch_act[ch]), .vld_o (ch_vld[ch])
		);
	end

	assign out_pixel_o = ch_act;
	assign out_valid_o = ch_vld[0];	// All channels run in lockstep

endmodule

//--- bench/cnn_accel_chk.sv
`timescale 1ns/1ps
module cnn_accel_chk (
	input  logic               clk,
	input  logic               rstn,
	input  bus_pkg::ahb_req_t  bus_i,
	input  logic               busy_i,
	input  logic               data_run_i,
	input  logic               hready_i,
	input  logic               pix_we_i
);

	int n_fail = 0;	// Failed assertions so far

	// Rows only start out of vsync or hsync
	a_run_from_busy: assert property (@(posedge clk) disable iff (!rstn)
		$rose(data_run_i) |-> $past(busy_i))
		else begin
			n_fail++;
			$error("data_run rose while the frame sequencer was idle");
		end

	a_hready_high: assert property (@(posedge clk) disable iff (!rstn) hready_i)
		else begin
			n_fail++;
			$error("hready_o dropped low");
		end

	// Pixel strobe needs an accepted image write address phase one cycle earlier
	a_pix_we_phase: assert property (@(posedge clk) disable iff (!rstn)
		pix_we_i |-> $past(bus_i.sel && bus_i.ready && bus_i.write && bus_i.trans[1] &&
			bus_i.addr[bus_pkg::ADDR_SEL_LSB +: bus_pkg::W_REG_SEL] ==
			bus_pkg::REG_INPUT_IMAGE))
		else begin
			n_fail++;
			$error("Pixel write strobe outside a bus data phase");
		end

endmodule

//--- bench/tb_cnn_accel.sv
`timescale 1ns/1ps
module tb_cnn_accel;

	localparam int N_PIX      = 16;	// 4x4 frame
	localparam int N_WORDS    = 3 + 3*N_PIX;
	localparam int VLD_LIMIT  = 200;	// Cycles allowed per output pixel
	localparam int DONE_LIMIT = 400;	// Done polls per frame
	localparam logic [31:0] DELAY_WORD = 32'h0000_3006;	// hsync 3, start-up 6

	logic               clk, rstn;
	bus_pkg::ahb_req_t  bus;
	logic               hready, out_valid;
	logic [1:0]         hresp;
	logic [31:0]        hrdata, out_pixel;
	logic [31:0]        vec [N_WORDS];	// Config, pixels, expected words
	int                 n_chk, n_err, n_timeout, n_valid, n_assert;
	bit                 timed_out;

	cnn_accel_top u_dut (
		.clk (clk), .rstn (rstn), .bus_i (bus),
		.hready_o (hready), .hresp_o (hresp), .hrdata_o (hrdata),
		.out_pixel_o (out_pixel), .out_valid_o (out_valid)
	);

	bind cnn_ctrl cnn_accel_chk u_chk (
		.clk (clk), .rstn (rstn), .bus_i (bus_i), .busy_i (busy),
		.data_run_i (data_run), .hready_i (hready_o), .pix_we_i (pix_we_o)
	);

	always #50 clk = ~clk;

	always @(negedge clk) begin
		if (out_valid) n_valid++;	// Sampled mid-cycle once flops settle
	end

	// --------------------
	// Bus and check helpers
	task automatic check_val(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		n_chk++;
		if (act !== exp) begin
			n_err++;
			$display("[FAIL] %s expected %08h actual %08h", name, exp, act);
		end
	endtask

	task automatic write_reg(input logic [3:0] sel, input logic [7:0] idx,
		input logic [31:0] data);
		bus.sel   = 1'b1;
		bus.trans = bus_pkg::TRANS_NONSEQ;
		bus.addr  = {16'd0, idx, 2'b00, sel, 2'b00};	// Pixel index above the select
		bus.write = 1'b1;
		@(posedge clk);
		#1;
		bus.sel   = 1'b0;	// Data phase
		bus.trans = 2'b00;
		bus.write = 1'b0;
		bus.wdata = data;
		@(posedge clk);
		#1;
	endtask

	task automatic read_reg(input logic [3:0] sel, output logic [31:0] data,
		output logic [1:0] resp);
		bus.sel   = 1'b1;
		bus.trans = bus_pkg::TRANS_NONSEQ;
		bus.addr  = {26'd0, sel, 2'b00};
		bus.write = 1'b0;
		@(posedge clk);
		#1;
		bus.sel   = 1'b0;
		bus.trans = 2'b00;
		data = hrdata;	// Valid in data phase
		resp = hresp;
	endtask

	task automatic wait_out_valid(input string tag);
		int n;
		n = 0;
		do begin
			@(posedge clk);
			#1;
			n++;
		end while (!out_valid && n < VLD_LIMIT);
		if (!out_valid) begin
			timed_out = 1'b1;
			n_timeout++;
			$display("Timeout: no output pixel within %0d cycles in the %s frame",
				VLD_LIMIT, tag);
		end
	endtask

	task automatic wait_done(input string tag);
		logic [31:0] rd;
		logic [1:0]  resp;
		int          n;
		n = 0;
		do begin
			read_reg(bus_pkg::REG_LAYER_DONE, rd, resp);
			n++;
		end while (rd[0] !== 1'b1 && n < DONE_LIMIT);
		if (rd[0] !== 1'b1) begin
			timed_out = 1'b1;
			n_timeout++;
			$display("Timeout: done flag never set in the %s frame", tag);
		end
	endtask

	// --------------------
	// One frame with n_exp outputs taken from vec[base]
	task automatic run_frame(input string tag, input logic [31:0] cfg, input int base,
		input int n_exp);
		logic [31:0] rd;
		logic [1:0]  resp;
		int          n_start;
		write_reg(bus_pkg::REG_LAYER_CONFIG, 8'd0, cfg);
		n_start = n_valid;
		write_reg(bus_pkg::REG_LAYER_START, 8'd0, 32'd1);
		read_reg(bus_pkg::REG_LAYER_DONE, rd, resp);
		check_val({tag, " done after start"}, 32'd0, rd);
		for (int i = 0; i < n_exp; i++) begin
			wait_out_valid(tag);
			if (timed_out) return;
			check_val($sformatf("%s pixel %0d", tag, i), vec[base + i], out_pixel);
		end
		wait_done(tag);
		if (timed_out) return;
		repeat (cnn_pkg::KERN_LATENCY) @(posedge clk);	// Drain kernel pipe
		#1;
		check_val({tag, " output count"}, n_exp, n_valid - n_start);
	endtask

	task automatic run_tests;
		logic [31:0] rd;
		logic [1:0]  resp;
		if ($isunknown(vec[N_WORDS-1])) begin
			n_err++;
			$display("Data file bench/tb_input.hex is missing or short");
			return;
		end
		write_reg(bus_pkg::REG_WIDTH_HEIGHT, 8'd0, vec[0]);
		write_reg(bus_pkg::REG_DELAY_PARAMS, 8'd0, DELAY_WORD);
		write_reg(bus_pkg::REG_LAYER_CONFIG, 8'd0, vec[1]);
		read_reg(bus_pkg::REG_WIDTH_HEIGHT, rd, resp);
		check_val("geometry readback", vec[0], rd);
		read_reg(bus_pkg::REG_DELAY_PARAMS, rd, resp);
		check_val("delay readback", DELAY_WORD, rd);
		read_reg(bus_pkg::REG_LAYER_CONFIG, rd, resp);
		check_val("layer config readback", vec[1], rd);
		read_reg(4'd3, rd, resp);	// Unmapped
		check_val("unmapped readback", 32'd0, rd);
		check_val("unmapped hresp", 32'd0, resp);
		check_val("hready", 32'd1, hready);
		for (int i = 0; i < N_PIX; i++) begin
			write_reg(bus_pkg::REG_INPUT_IMAGE, i[7:0], vec[3 + i]);
		end
		run_frame("relu", vec[1], 3 + N_PIX, N_PIX);
		if (timed_out) return;
		run_frame("linear", vec[2], 3 + 2*N_PIX, N_PIX);
		if (timed_out) return;
		run_frame("gated", vec[1] & ~32'h1, 0, 0);	// is_first_layer cleared
	endtask

	initial begin
		clk       = 1'b0;
		rstn      = 1'b0;
		bus       = '0;
		bus.ready = 1'b1;
		n_chk     = 0;
		n_err     = 0;
		n_timeout = 0;
		n_valid   = 0;
		n_assert  = 0;
		timed_out = 1'b0;
		$readmemh("bench/tb_input.hex", vec);
		repeat (3) @(posedge clk);
		#1;
		rstn = 1'b1;
		run_tests();
		n_assert = u_dut.u_ctrl.u_chk.n_fail;
		$display("Checks %0d, mismatches %0d, timeouts %0d, assertion failures %0d",
			n_chk, n_err, n_timeout, n_assert);
		if (n_err == 0 && n_timeout == 0 && n_assert == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- bench/tb_input.hex
// One 32-bit word per line: geometry, ReLU config, linear config, 16 pixels,
// 16 expected ReLU words, 16 expected linear words; result bytes {ch3,ch2,ch1,ch0}
00040004
0000A601
0000A609
// Pixels in raster order
00000004
00000004
00000004
00000004
00000004
00000004
00000004
00000004
00000004
00000004
00000004
00000004
00000004
00000004
00000004
00000004
// Expected ReLU outputs
1B4DFF00
0040FF00
0040FF00
004AF700
0044F600
0040FF00
0040FF00
004BF600
0044F600
0040FF00
0040FF00
004BF600
0051DC00
004FEE00
004FEE00
005BE400
// Expected linear outputs
1B4D7F80
00407F80
00407F80
F14A7F80
EB447F80
E8407F80
E8407F80
E04B7F80
EB447F80
E8407F80
E8407F80
E04B7F80
E9517F80
D54F7F80
D54F7F80
BF5B7F80

//--- build.f
source/bus_pkg.sv
source/cnn_pkg.sv
source/conv_act_quant.sv
source/conv_kern.sv
source/img_window_buf.sv
source/cnn_ctrl.sv
source/cnn_accel_top.sv
bench/cnn_accel_chk.sv
bench/tb_cnn_accel.sv

//--- Bender.yml
package:
  name: cnn_accel

sources:
  - source/bus_pkg.sv
  - source/cnn_pkg.sv
  - source/conv_act_quant.sv
  - source/conv_kern.sv
  - source/img_window_buf.sv
  - source/cnn_ctrl.sv
  - source/cnn_accel_top.sv
  - target: test
    files:
      - bench/cnn_accel_chk.sv
      - bench/tb_cnn_accel.sv
